// File: src/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Serial line types, 8N1 framing
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] uart_byte_t;    // One data byte
    typedef logic [3:0] uart_bitcnt_t;  // Start, 8 data, stop

    // Receiver report, one per frame
    typedef struct packed {
        logic       valid;      // Single cycle strobe
        logic       frame_err;  // Stop bit sampled low
        uart_byte_t data;
    } rx_event_t;

    // Transmit request
    typedef struct packed {
        logic       start;      // Single cycle strobe
        uart_byte_t data;
    } tx_cmd_t;

endpackage

// File: src/echo_pkg.sv
package echo_pkg;

    import uart_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Loop-back control types
    ////////////////////////////////////////////////////////////////////////////

    // Echo sequencer
    typedef enum logic [1:0] {
        IDLE,       // Wait for a held byte and a free transmitter
        LAUNCH,     // Start strobe to the transmitter
        WAIT_BUSY   // Until the transmitter takes it
    } echo_state_t;

    // One byte buffer between receiver and transmitter
    typedef struct packed {
        logic       full;
        uart_byte_t data;
    } hold_t;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ  = 100_000_000,  // Hz
    parameter int unsigned BAUD_RATE = 115_200       // Bit/s
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      rx,           // Serial in, idle high
    output rx_event_t rx_evt,
    output logic      frame_error   // Bad stop bit, one cycle
);

    ////////////////////////////////////////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned BIT_P   = CLK_FREQ / BAUD_RATE;  // Cycles per bit
    localparam int unsigned HALF_P  = BIT_P / 2;
    localparam int unsigned TIMER_W = $clog2(BIT_P);

    typedef logic [TIMER_W-1:0] timer_t;

    localparam uart_bitcnt_t STOP_BIT = 4'd9;  // Index of the stop bit

    typedef enum logic [1:0] {
        RX_IDLE,     // Armed, line high
        RX_START,    // Recheck start bit at half period
        RX_FRAME,    // Data and stop samples
        RX_RECOVER   // Wait for line high
    } rx_state_t;

    rx_state_t    state;
    timer_t       timer;
    uart_bitcnt_t bit_idx;
    logic         rx_meta;     // First synchronizer stage
    logic         rx_sync;     // Safe to use
    logic         sample;      // Middle of a bit in RX_FRAME
    uart_byte_t   shift_reg;   // Data, LSB first
    logic         evt_valid;
    logic         evt_err;

    // Two flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign sample = (state == RX_FRAME) && (timer == timer_t'(BIT_P - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RX_IDLE;
            timer     <= '0;
            bit_idx   <= '0;
            evt_valid <= 1'b0;
            evt_err   <= 1'b0;
        end else begin
            evt_valid <= 1'b0;  // Strobe by default
            case (state)
                RX_IDLE: begin
                    timer <= '0;
                    if (!rx_sync) state <= RX_START;  // Falling edge, armed only when high
                end
                RX_START: begin
                    if (timer == timer_t'(HALF_P - 1)) begin
                        timer <= '0;
                        if (!rx_sync) begin  // Still low, real start bit
                            bit_idx <= 4'd1;
                            state   <= RX_FRAME;
                        end else begin
                            state   <= RX_IDLE;  // Glitch
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_FRAME: begin
                    if (sample) begin
                        timer   <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == STOP_BIT) begin
                            evt_valid <= 1'b1;
                            evt_err   <= !rx_sync;  // Stop must be high
                            state     <= RX_RECOVER;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_RECOVER: if (rx_sync) state <= RX_IDLE;
                default:    state <= RX_IDLE;
            endcase
        end
    end

    // Data bits only, stop sample leaves the byte intact
    always_ff @(posedge clk) begin
        if (sample && bit_idx != STOP_BIT) shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    assign rx_evt = '{valid: evt_valid, frame_err: evt_err, data: shift_reg};

    // The only place the error condition is decoded
    assign frame_error = evt_valid && evt_err;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ  = 100_000_000,  // Hz
    parameter int unsigned BAUD_RATE = 115_200       // Bit/s
) (
    input  logic    clk,
    input  logic    reset,
    input  tx_cmd_t tx_cmd,
    output logic    tx,     // Serial out, idle high
    output logic    busy    // Frame in flight
);

    ////////////////////////////////////////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned BIT_P   = CLK_FREQ / BAUD_RATE;
    localparam int unsigned TIMER_W = $clog2(BIT_P);

    typedef logic [TIMER_W-1:0] timer_t;
    typedef logic [9:0]         frame_t;  // Stop, data, start

    localparam uart_bitcnt_t STOP_BIT = 4'd9;

    timer_t       timer;
    uart_bitcnt_t bit_idx;    // Bit now on the line
    frame_t       shift_reg;
    logic         load;
    logic         bit_end;

    assign load    = tx_cmd.start && !busy;  // Ignored mid frame
    assign bit_end = busy && (timer == timer_t'(BIT_P - 1));

    // Control
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            timer   <= '0;
            bit_idx <= '0;
        end else if (load) begin
            busy    <= 1'b1;  // Start bit from next cycle
            timer   <= '0;
            bit_idx <= '0;
        end else if (busy) begin
            if (bit_end) begin
                timer   <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == STOP_BIT) busy <= 1'b0;  // Stop bit done
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

    // Payload, LSB first, fill with idle level
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= {1'b1, tx_cmd.data, 1'b0};
        end else if (bit_end) begin
            shift_reg <= {1'b1, shift_reg[9:1]};
        end
    end

    // Line rests high between frames
    assign tx = busy ? shift_reg[0] : 1'b1;

endmodule

// File: src/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl
    import uart_pkg::*, echo_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  rx_event_t rx_evt,
    input  logic      busy,     // Transmitter in a frame
    output tx_cmd_t   tx_cmd,
    output logic      led       // Byte accepted, echo not yet started
);

    echo_state_t state;
    hold_t       hold;
    logic        accept;  // Good frame from the receiver

    assign accept = rx_evt.valid && !rx_evt.frame_err;

    ////////////////////////////////////////////////////////////////////////////
    // Hold register and echo sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            hold.full <= 1'b0;
            led       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (hold.full && !busy) state <= LAUNCH;
                end
                LAUNCH: begin
                    hold.full <= 1'b0;  // Byte handed to the transmitter
                    state     <= WAIT_BUSY;
                end
                WAIT_BUSY: begin
                    if (busy) begin  // Echo under way
                        led   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // New byte wins over the clears above
            if (accept) begin
                hold.full <= 1'b1;
                hold.data <= rx_evt.data;  // Overwrites if still full
                led       <= 1'b1;
            end
        end
    end

    assign tx_cmd = '{start: (state == LAUNCH), data: hold.data};

endmodule

// File: src/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ  = 100_000_000,  // Hz
    parameter int unsigned BAUD_RATE = 115_200       // Bit/s
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,           // Serial in, idle high
    output logic tx,           // Serial out
    output logic led,
    output logic frame_error   // Pulse per bad frame
);

    ////////////////////////////////////////////////////////////////////////////
    // Receiver -> controller -> transmitter
    ////////////////////////////////////////////////////////////////////////////

    rx_event_t rx_evt;
    tx_cmd_t   tx_cmd;
    logic      busy;

    uart_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_rx_i (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .rx_evt      (rx_evt),
        .frame_error (frame_error)
    );

    echo_ctrl echo_ctrl_i (
        .clk    (clk),
        .reset  (reset),
        .rx_evt (rx_evt),
        .busy   (busy),
        .tx_cmd (tx_cmd),
        .led    (led)
    );

    uart_tx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_tx_i (
        .clk    (clk),
        .reset  (reset),
        .tx_cmd (tx_cmd),
        .tx     (tx),
        .busy   (busy)
    );

endmodule

// File: include/uart_bench_tasks.svh
`ifndef UART_BENCH_TASKS_SVH
`define UART_BENCH_TASKS_SVH

// Uses clk, rx, tx, CLK_FREQ and BAUD_RATE of the including testbench

// Clock cycles per bit
function automatic int unsigned bit_cycles();
    return CLK_FREQ / BAUD_RATE;
endfunction

task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
endtask

// One 8N1 frame on rx, stop level selectable for error cases
task automatic send_frame(input uart_byte_t data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        rx <= frame[i];
        wait_cycles(bit_cycles() - 1);  // Full bit period
    end
    if (!stop_bit) begin  // Return the line to idle
        @(posedge clk);
        rx <= 1'b1;
        wait_cycles(bit_cycles() - 1);
    end
endtask

// Next frame on tx, each bit sampled at its middle
task automatic capture_frame(output uart_byte_t data, output logic frame_ok);
    logic [9:0] bits;
    @(negedge tx);  // Leading edge of the start bit
    wait_cycles(bit_cycles() / 2);
    bits[0] = tx;
    for (int i = 1; i < 10; i++) begin
        wait_cycles(bit_cycles());
        bits[i] = tx;
    end
    data     = bits[8:1];
    frame_ok = !bits[0] && bits[9];  // Start low, stop high
endtask

`endif

// File: bench/uart_echo_tb.sv
`timescale 1ns/1ps

module uart_echo_tb
    import uart_pkg::*;
();

    ////////////////////////////////////////////////////////////////////////////
    // Setup for a 10 cycle bit period
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned CLK_FREQ      = 1_000_000;
    localparam int unsigned BAUD_RATE     = 100_000;
    localparam int unsigned NUM_BURST     = 20;             // Back to back frames
    localparam int unsigned NUM_FRAMES    = NUM_BURST + 3;  // Single, bad, recovery
    localparam int unsigned MARGIN_CYCLES = 2000;           // Reset, idle and gaps

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic led;
    logic frame_error;

    int unsigned mismatch_count  = 0;
    int unsigned other_count     = 0;
    int unsigned led_rises       = 0;
    int unsigned led_falls       = 0;
    int unsigned fe_cycles       = 0;  // Cycles with frame_error high
    int unsigned expected_fe     = 0;
    int unsigned good_sent       = 0;
    int unsigned frames_captured = 0;
    logic        led_prev;
    uart_byte_t  expected_q[$];        // Echoes still owed in order
    integer      seed = 32'h451f;

    `include "uart_bench_tasks.svh"

    uart_echo_top #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_echo_top_i (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .tx          (tx),
        .led         (led),
        .frame_error (frame_error)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // Expected echo of one frame with bit 8 set when an echo is due
    function automatic logic [8:0] reference_echo(input uart_byte_t data, input logic stop_bit);
        return {stop_bit, data};  // No echo for a low stop bit
    endfunction

    task automatic report_fault(input string what);
        $display("ERROR at %0t: %s", $time, what);
        other_count++;
    endtask

    task automatic report_mismatch(input string name, input int unsigned got,
                                   input int unsigned want);
        $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        mismatch_count++;
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures, %0d echoes captured",
                 mismatch_count, other_count, frames_captured);
    endtask

    // Model first and then drive the line
    task automatic send_modeled(input uart_byte_t data, input logic stop_bit);
        logic [8:0] echo;
        echo = reference_echo(data, stop_bit);
        if (echo[8]) begin
            expected_q.push_back(echo[7:0]);
            good_sent++;
        end else begin
            expected_fe++;  // One pulse per bad frame
        end
        send_frame(data, stop_bit);
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $unsigned($random(seed)) % 64;
        wait_cycles(gap + 1);  // rx rests high
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and final checks
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        rx    = 1'b1;
        wait_cycles(5);
        reset <= 1'b0;

        // Quiet outputs after reset
        repeat (50) begin
            @(posedge clk);
            assert (tx === 1'b1) else report_fault("tx left its idle level after reset");
            assert (led === 1'b0) else report_fault("led set with no byte received");
            assert (frame_error === 1'b0) else report_fault("frame_error pulsed on idle line");
        end

        send_modeled(uart_byte_t'($random(seed)), 1'b1);  // Single byte
        idle_gap();
        for (int i = 0; i < NUM_BURST; i++) begin
            send_modeled(uart_byte_t'($random(seed)), 1'b1);  // No gap between frames
        end
        idle_gap();
        send_modeled(uart_byte_t'($random(seed)), 1'b0);  // Stop bit low
        // Earlier echoes have all started by now
        assert (led === 1'b0) else report_fault("led set by a frame with a low stop bit");
        idle_gap();
        send_modeled(uart_byte_t'($random(seed)), 1'b1);  // Recovery

        while (expected_q.size() != 0) @(posedge clk);
        wait_cycles(24 * bit_cycles());  // Room for a stray echo

        assert (led_rises == good_sent) else report_mismatch("led rises", led_rises, good_sent);
        assert (led_falls == good_sent) else report_mismatch("led falls", led_falls, good_sent);
        assert (fe_cycles == expected_fe)
            else report_mismatch("frame_error cycles", fe_cycles, expected_fe);
        assert (frames_captured == good_sent)
            else report_mismatch("echo frames", frames_captured, good_sent);
        assert (led === 1'b0) else report_fault("led still high after all echoes");

        print_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Edge counters for led and frame_error
    always @(posedge clk) begin
        if (reset) begin
            led_prev <= 1'b0;
        end else begin
            if (led && !led_prev) led_rises++;
            if (!led && led_prev) led_falls++;
            if (frame_error) fe_cycles++;
            led_prev <= led;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Echo compare
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare_echoes
        uart_byte_t got;
        uart_byte_t want;
        logic       frame_ok;
        forever begin
            capture_frame(got, frame_ok);
            frames_captured++;
            assert (frame_ok) else report_fault("echo frame has a bad start or stop bit");
            // led of this byte drops when its echo starts
            assert (led_falls >= frames_captured)
                else report_fault("led still high when its echo frame ended");
            assert (expected_q.size() != 0) else report_fault("echo frame with no byte owed");
            if (expected_q.size() != 0) begin
                want = expected_q.pop_front();
                assert (got == want) else report_mismatch("tx data", 32'(got), 32'(want));
            end
        end
    end

    // Frames times 12 bit periods plus drain wait and margin
    initial begin : watchdog
        repeat ((NUM_FRAMES * 12 + 24) * bit_cycles() + MARGIN_CYCLES) @(posedge clk);
        $display("ERROR: timeout, echoes did not finish in the expected time");
        print_counts();
        $display("Verification failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
src/uart_pkg.sv
src/echo_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/echo_ctrl.sv
src/uart_echo_top.sv
bench/uart_echo_tb.sv

// File: Makefile
# Verilator build and run for the UART loop-back testbench

VERILATOR ?= verilator
TOP       ?= uart_echo_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/uart_bench_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator's exit code
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
